// ==== filelist.f ====
source/adc_pkg.sv
source/adc_apb_regs.sv
source/modulation_sequencer.sv
source/charge_counters.sv
source/result_capture.sv
source/adc_modulation_top.sv
bench/integrator_model.sv
bench/tb_adc_modulation.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench, exit status is the verdict
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal --top-module tb_adc_modulation \
  -f filelist.f -o tb_adc_modulation &&
./obj_dir/tb_adc_modulation || exit 1

// ==== bench/tb_adc_modulation.sv ====
`default_nettype none

module tb_adc_modulation;
  import adc_pkg::*;

  localparam int CLK_PERIOD  = 10;
  localparam int NUM_ROWS    = 4;
  // clocks allowed per measurement beyond its aperture
  localparam int ROW_MARGIN  = 4000;
  localparam int SETUP_CLKS  = 500;
  localparam int RESTART_ROW = 1;

  // one measurement setup with its fixed expectations
  typedef struct packed {
    long_cnt_t          aperture;
    short_cnt_t         reset_len;
    short_cnt_t         fix_len;
    short_cnt_t         var_len;
    logic               slow;
    logic signed [15:0] level;
    short_cnt_t         exp_reset_clks;
    long_cnt_t          exp_sig_clks;
    short_cnt_t         exp_min_cycles;
    refmux_e            exp_rd_mux;
  } row_t;

  // min cycles is aperture over 2*(fix+var), rounded up
  row_t rows [NUM_ROWS] = '{
    '{32'd200, 24'd5,  24'd4, 24'd4, 1'b0,  16'sd150, 24'd5,  32'd200, 24'd13, REFMUX_POS},
    '{32'd333, 24'd1,  24'd3, 24'd5, 1'b1, -16'sd120, 24'd1,  32'd333, 24'd21, REFMUX_SLOW_POS},
    '{32'd97,  24'd12, 24'd3, 24'd4, 1'b0,  16'sd60,  24'd12, 32'd97,  24'd7,  REFMUX_POS},
    '{32'd500, 24'd3,  24'd6, 24'd8, 1'b1,  16'sd200, 24'd3,  32'd500, 24'd18, REFMUX_SLOW_POS}
  };

  logic                  clk = 1'b0;
  logic                  rst;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [APB_ADDR_W-1:0] paddr;
  logic [31:0]           pwdata;
  logic [31:0]           prdata;
  logic                  pready;
  logic                  pslverr;
  logic                  comparator;
  refmux_e               refmux;
  logic                  sigmux;
  logic                  cmpr_disable;

  logic signed [15:0] row_level;
  logic signed [15:0] sig_level;
  integer             seed = 32'h68cb93f7;
  int                 errors = 0;
  // switch codes seen since the last negative reference clock
  refmux_e            rd_log [$];

  adc_modulation_top #(.SYNC_STAGES(2)) DUT (
    .clk(clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .comparator(comparator), .refmux(refmux), .sigmux(sigmux), .cmpr_disable(cmpr_disable)
  );

  integrator_model u_integrator (
    .clk(clk), .rst(rst), .refmux(refmux), .sigmux(sigmux), .sig_level(sig_level),
    .comparator(comparator)
  );

  always #(CLK_PERIOD/2) clk = ~clk;

  // small noise on the signal level with a new value each clock
  always @(posedge clk)
  begin
    #1;
    sig_level = row_level + 16'($random(seed) % 8);
  end

  // rundown monitor where the prerundown clock is the last negative one
  always @(negedge clk)
  begin
    if (rst)
      rd_log.delete();
    else if (refmux == REFMUX_NEG)
      rd_log.delete();
    else if (refmux != REFMUX_RESET)
      rd_log.push_back(refmux);
  end

  //////////////////////////////////////////////////
  // checks

  task automatic fail_run(input string what);
    errors = errors + 1;
    $display("%s", what);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_count(input string name, input long_cnt_t expected,
                             input long_cnt_t actual);
    if (actual !== expected)
      fail_run($sformatf("Error: %s expected %0d actual %0d", name, expected, actual));
  endtask

  task automatic check_min_count(input string name, input long_cnt_t minimum,
                                 input long_cnt_t actual);
    if (actual < minimum)
      fail_run($sformatf("Error: %s expected at least %0d actual %0d", name, minimum, actual));
  endtask

  task automatic check_refmux(input string name, input refmux_e expected,
                              input refmux_e actual);
    if (actual !== expected)
      fail_run($sformatf("Error: %s expected %s actual %s", name, expected.name(),
                         actual.name()));
  endtask

  //////////////////////////////////////////////////
  // apb master

  // setup cycle then access cycle sampled mid access
  task automatic apb_transfer(input logic write, input logic [APB_ADDR_W-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
    @(posedge clk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;
    @(negedge clk);
    rdata = prdata;
    err   = pslverr;
    if (pready !== 1'b1)
      fail_run("pready was low in an access cycle");
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic write_reg(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] data);
    logic [31:0] rdata_ignored;
    logic        err;
    apb_transfer(1'b1, addr, data, rdata_ignored, err);
    if (err)
      fail_run($sformatf("slave error on a write to legal address 0x%02h", addr));
  endtask

  task automatic read_reg(input logic [APB_ADDR_W-1:0] addr, output logic [31:0] data);
    logic err;
    apb_transfer(1'b0, addr, 32'd0, data, err);
    if (err)
      fail_run($sformatf("slave error on a read of legal address 0x%02h", addr));
  endtask

  //////////////////////////////////////////////////
  // measurement steps

  // poll status until the result is latched
  task automatic wait_valid();
    logic [31:0] status;
    status = '0;
    while (status[0] !== 1'b1)
      read_reg(REG_CTRL, status);
  endtask

  // the trigger shorts the integrator and stops the signal at once
  task automatic start_conversion(input string tag);
    logic [31:0] status;
    write_reg(REG_CTRL, 32'd1);
    @(negedge clk);
    check_count($sformatf("%s sigmux after trigger", tag), 32'd0, 32'(sigmux));
    check_refmux($sformatf("%s refmux after trigger", tag), REFMUX_RESET, refmux);
    read_reg(REG_CTRL, status);
    check_count($sformatf("%s valid after trigger", tag), 32'd0, 32'(status[0]));
  endtask

  task automatic load_row(input int idx, input string tag);
    write_reg(REG_APERTURE, rows[idx].aperture);
    write_reg(REG_RESET, 32'(rows[idx].reset_len));
    write_reg(REG_FIX, 32'(rows[idx].fix_len));
    write_reg(REG_VAR, 32'(rows[idx].var_len));
    write_reg(REG_MODE, {31'd0, rows[idx].slow});
    row_level = rows[idx].level;
    start_conversion(tag);
  endtask

  task automatic read_results(output adc_result_t res);
    logic [31:0] d;
    read_reg(REG_RESET_CLKS, d);
    res.reset_clks = d[SHORT_W-1:0];
    read_reg(REG_SIG_CLKS, d);
    res.sig_clks = d;
    read_reg(REG_POS_CLKS, d);
    res.pos_clks = d;
    read_reg(REG_NEG_CLKS, d);
    res.neg_clks = d;
    read_reg(REG_RUNDOWN_CLKS, d);
    res.rundown_clks = d[SHORT_W-1:0];
    read_reg(REG_CYCLES, d);
    res.cycles = d[SHORT_W-1:0];
    read_reg(REG_VAR_UPS, d);
    res.var_ups = d[SHORT_W-1:0];
    read_reg(REG_VAR_DOWNS, d);
    res.var_downs = d[SHORT_W-1:0];
  endtask

  // charge balance of complete four phase cycles plus one prerundown clock
  task automatic check_row(input int idx, input string tag, input adc_result_t res);
    long_cnt_t cyc;
    long_cnt_t ups;
    long_cnt_t downs;
    long_cnt_t f;
    long_cnt_t w;
    cyc   = 32'(res.cycles);
    ups   = 32'(res.var_ups);
    downs = 32'(res.var_downs);
    f     = 32'(rows[idx].fix_len);
    w     = 32'(rows[idx].var_len);
    check_count($sformatf("%s reset_clks", tag), 32'(rows[idx].exp_reset_clks),
                32'(res.reset_clks));
    check_count($sformatf("%s sig_clks", tag), rows[idx].exp_sig_clks, res.sig_clks);
    check_count($sformatf("%s var phases", tag), 2 * cyc, ups + downs);
    check_count($sformatf("%s pos_clks", tag), f * cyc + w * downs, res.pos_clks);
    check_count($sformatf("%s neg_clks", tag), f * cyc + w * ups + 1, res.neg_clks);
  endtask

  task automatic check_rundown(input int idx, input string tag, input adc_result_t res);
    check_min_count($sformatf("%s cycles", tag), 32'(rows[idx].exp_min_cycles),
                    32'(res.cycles));
    check_min_count($sformatf("%s rundown_clks", tag), 32'd1, 32'(res.rundown_clks));
    // every rundown clock was seen on the switch outputs
    check_count($sformatf("%s rundown monitor length", tag), 32'(res.rundown_clks),
                32'(rd_log.size()));
    foreach (rd_log[i])
      check_refmux($sformatf("%s rundown refmux", tag), rows[idx].exp_rd_mux, rd_log[i]);
  endtask

  task automatic check_after_reset();
    logic [APB_ADDR_W-1:0] cfg_addr [5] = '{REG_APERTURE, REG_RESET, REG_FIX, REG_VAR,
                                           REG_MODE};
    logic [31:0]           cfg_val [5]  = '{32'hA5C3_1234, 32'h00AB_CDEF, 32'h0012_3456,
                                           32'h000F_0F0F, 32'h0000_0001};
    logic [31:0]           d;
    logic                  err;
    read_reg(REG_CTRL, d);
    check_count("reset status", 32'd0, d);
    @(negedge clk);
    check_refmux("reset refmux", REFMUX_RESET, refmux);
    check_count("reset sigmux", 32'd0, 32'(sigmux));
    check_count("reset cmpr_disable", 32'd1, 32'(cmpr_disable));
    for (int i = 0; i < 5; i++)
    begin
      read_reg(cfg_addr[i], d);
      check_count($sformatf("reset value 0x%02h", cfg_addr[i]), 32'd0, d);
      write_reg(cfg_addr[i], cfg_val[i]);
      read_reg(cfg_addr[i], d);
      check_count($sformatf("readback 0x%02h", cfg_addr[i]), cfg_val[i], d);
    end
    // hole in the map and a write to a read only result
    apb_transfer(1'b0, 8'h40, 32'd0, d, err);
    if (err !== 1'b1)
      fail_run("no slave error on a read of unmapped offset 0x40");
    apb_transfer(1'b1, REG_VAR_DOWNS, 32'd5, d, err);
    if (err !== 1'b1)
      fail_run("no slave error on a write to result offset 0x3c");
  endtask

  //////////////////////////////////////////////////
  // main sequence

  initial
  begin
    adc_result_t res;
    string       tag;
    rst       = 1'b1;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    row_level = '0;
    sig_level = '0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    check_after_reset();

    for (int i = 0; i < NUM_ROWS; i++)
    begin
      tag = $sformatf("row%0d", i);
      load_row(i, tag);
      wait_valid();
      read_results(res);
      check_row(i, tag, res);
      check_rundown(i, tag, res);
    end

    // second trigger lands in the middle of the aperture
    load_row(RESTART_ROW, "restart first");
    repeat (rows[RESTART_ROW].reset_len + rows[RESTART_ROW].aperture / 2) @(posedge clk);
    #1;
    start_conversion("restart second");
    wait_valid();
    read_results(res);
    check_row(RESTART_ROW, "restart", res);
    check_rundown(RESTART_ROW, "restart", res);

    if (errors == 0)
    begin
      $display("ALL TESTS PASSED");
      $finish;
    end
    else
    begin
      $display("SOME TESTS FAILED");
      $fatal(1, "errors found");
    end
  end

  // watchdog budget comes from the table apertures
  initial
  begin
    long_cnt_t budget;
    budget = SETUP_CLKS;
    for (int i = 0; i < NUM_ROWS; i++)
      budget = budget + rows[i].aperture + ROW_MARGIN;
    // restart test runs its row a second time
    budget = budget + rows[RESTART_ROW].aperture + ROW_MARGIN;
    repeat (budget) @(posedge clk);
    $display("watchdog expired before the tests finished");
    $display("SOME TESTS FAILED");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

// ==== bench/integrator_model.sv ====
`default_nettype none

module integrator_model (
  input  wire                   clk,
  input  wire                   rst,
  input  wire adc_pkg::refmux_e refmux,
  input  wire                   sigmux,
  input  wire signed [15:0]     sig_level,
  output logic                  comparator
);
  import adc_pkg::*;

  //////////////////////////////////////////////////
  // charge per clock in arbitrary units

  // positive reference slightly stronger than negative
  // so the residue keeps drifting down after the aperture
  localparam int POS_STEP  = 1000;
  localparam int NEG_STEP  = 950;
  // slow rundown reference, a small fraction of pos
  localparam int SLOW_STEP = 50;

  // integrator output
  int level;
  // change over the current clock
  int delta;

  always_comb
  begin
    delta = 0;
    // signal pushes up for a positive level
    if (sigmux)
      delta = delta + int'(sig_level);
    case (refmux)
      REFMUX_POS:      delta = delta - POS_STEP;
      REFMUX_NEG:      delta = delta + NEG_STEP;
      REFMUX_SLOW_POS: delta = delta - SLOW_STEP;
      default:         ;
    endcase
  end

  //////////////////////////////////////////////////
  // integrator

  // reset switch shorts the capacitor
  always @(posedge clk)
  begin
    if (rst)
      level <= 0;
    else if (refmux == REFMUX_RESET)
      level <= 0;
    else
      level <= level + delta;
  end

  // high while below the zero cross
  assign comparator = level < 0;

endmodule

`default_nettype wire

// ==== source/adc_modulation_top.sv ====
`default_nettype none

module adc_modulation_top #(
  parameter int SYNC_STAGES = 2
) (
  input  wire                           clk,
  input  wire                           rst,
  input  wire                           psel,
  input  wire                           penable,
  input  wire                           pwrite,
  input  wire [adc_pkg::APB_ADDR_W-1:0] paddr,
  input  wire [31:0]                    pwdata,
  output logic [31:0]                   prdata,
  output logic                          pready,
  output logic                          pslverr,
  input  wire                           comparator,
  output adc_pkg::refmux_e              refmux,
  output logic                          sigmux,
  output logic                          cmpr_disable
);
  import adc_pkg::*;

  adc_cfg_t    cfg;
  logic        trigger;
  seq_event_t  ev;
  adc_result_t running;
  adc_result_t last;
  logic        valid;

  // host side registers and start pulse
  adc_apb_regs u_regs (
    .clk(clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .cfg(cfg), .trigger(trigger), .last(last), .valid(valid)
  );

  // switch control
  modulation_sequencer #(.SYNC_STAGES(SYNC_STAGES)) u_seq (
    .clk(clk), .rst(rst), .cfg(cfg), .trigger(trigger), .comparator(comparator),
    .ev(ev), .refmux(refmux), .sigmux(sigmux), .cmpr_disable(cmpr_disable)
  );

  charge_counters u_cnt (.clk(clk), .rst(rst), .ev(ev), .running(running));

  result_capture u_cap (.clk(clk), .rst(rst), .ev(ev), .running(running), .last(last),
    .valid(valid));

endmodule

`default_nettype wire

// ==== source/result_capture.sv ====
`default_nettype none

module result_capture (
  input  wire                       clk,
  input  wire                       rst,
  input  wire adc_pkg::seq_event_t  ev,
  input  wire adc_pkg::adc_result_t running,
  output adc_pkg::adc_result_t      last,
  output logic                      valid
);

  //////////////////////////////////////////////////
  // completion flag

  // drops at the start of a new conversion
  always_ff @(posedge clk)
  begin
    if (rst)
      valid <= 1'b0;
    else if (ev.clear)
      valid <= 1'b0;
    else if (ev.capture)
      valid <= 1'b1;
  end

  //////////////////////////////////////////////////
  // result hold

  // only capture writes here, so the previous result
  // stays readable while the next one accumulates
  always_ff @(posedge clk)
  begin
    if (ev.capture)
      last <= running;
  end

endmodule

`default_nettype wire

// ==== source/charge_counters.sv ====
`default_nettype none

module charge_counters (
  input  wire                     clk,
  input  wire                     rst,
  input  wire adc_pkg::seq_event_t ev,
  output adc_pkg::adc_result_t    running
);
  import adc_pkg::*;

  // set between clear and capture
  logic active;
  logic count_en;

  always_ff @(posedge clk)
  begin
    if (rst)
      active <= 1'b0;
    else if (ev.clear)
      active <= 1'b1;
    else if (ev.capture)
      active <= 1'b0;
  end

  // the capture clock sits in done and belongs to no phase
  assign count_en = active && !ev.capture;

  //////////////////////////////////////////////////
  // clock totals

  always_ff @(posedge clk)
  begin
    if (ev.clear)
    begin
      running <= '0;
    end
    else if (count_en)
    begin
      // rundown counted by phase, so pos holds modulation only
      if (ev.in_rundown)
        running.rundown_clks <= running.rundown_clks + 1'b1;
      else
      begin
        case (ev.refmux)
          REFMUX_RESET: running.reset_clks <= running.reset_clks + 1'b1;
          REFMUX_POS:   running.pos_clks   <= running.pos_clks + 1'b1;
          REFMUX_NEG:   running.neg_clks   <= running.neg_clks + 1'b1;
          // none and slow pos carry no modulation charge
          default:      ;
        endcase
      end

      if (ev.sigmux)
        running.sig_clks <= running.sig_clks + 1'b1;

      // phase statistics
      if (ev.cycle_start)
        running.cycles <= running.cycles + 1'b1;
      if (ev.var_up)
        running.var_ups <= running.var_ups + 1'b1;
      if (ev.var_down)
        running.var_downs <= running.var_downs + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== source/modulation_sequencer.sv ====
`default_nettype none

module modulation_sequencer #(
  parameter int SYNC_STAGES = 2
) (
  input  wire                       clk,
  input  wire                       rst,
  input  wire adc_pkg::adc_cfg_t    cfg,
  input  wire                       trigger,
  input  wire                       comparator,
  output adc_pkg::seq_event_t       ev,
  output adc_pkg::refmux_e          refmux,
  output logic                      sigmux,
  output logic                      cmpr_disable
);
  import adc_pkg::*;

  logic [SYNC_STAGES-1:0] cmpr_sync;
  logic                   cmpr_s;
  logic                   cmpr_prev;
  logic                   cmpr_cross;

  seq_state_e state;
  // clocks left in the current phase after this one
  short_cnt_t phase_cnt;
  long_cnt_t  ap_cnt;
  logic       dir_up;
  logic       capture_q;

  refmux_e var_mux;
  refmux_e rundown_mux;

  //////////////////////////////////////////////////
  // comparator synchronizer

  always_ff @(posedge clk)
  begin
    cmpr_sync[0] <= comparator;
    for (int i = 1; i < SYNC_STAGES; i++)
      cmpr_sync[i] <= cmpr_sync[i-1];
    cmpr_prev <= cmpr_s;
  end

  // high means integrator below the zero cross
  assign cmpr_s     = cmpr_sync[SYNC_STAGES-1];
  assign cmpr_cross = cmpr_s != cmpr_prev;

  // below the cross the negative reference drives up
  assign var_mux     = cmpr_s ? REFMUX_NEG : REFMUX_POS;
  assign rundown_mux = cfg.slow_rundown ? REFMUX_SLOW_POS : REFMUX_POS;

  //////////////////////////////////////////////////
  // sequence

  // switch codes are set on entry to each start state
  // so the start cycle is the first clock of its phase
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state        <= DONE;
      refmux       <= REFMUX_RESET;
      sigmux       <= 1'b0;
      cmpr_disable <= 1'b1;
      capture_q    <= 1'b0;
      dir_up       <= 1'b0;
      phase_cnt    <= '0;
      ap_cnt       <= '0;
    end
    else if (trigger)
    begin
      // abandon anything in flight and short the integrator
      state        <= RESET_START;
      refmux       <= REFMUX_RESET;
      sigmux       <= 1'b0;
      cmpr_disable <= 1'b1;
      capture_q    <= 1'b0;
    end
    else
    begin
      capture_q <= 1'b0;

      // aperture timer runs beside the phase cycling
      if (sigmux)
      begin
        if (ap_cnt <= 32'd1)
          sigmux <= 1'b0;
        else
          ap_cnt <= ap_cnt - 1'b1;
      end

      case (state)
        DONE:
        begin
          // parked with the integrator shorted
          refmux       <= REFMUX_RESET;
          cmpr_disable <= 1'b1;
        end

        RESET_START:
        begin
          state     <= RESET;
          phase_cnt <= cfg.reset_len;
        end

        RESET:
        begin
          if (phase_cnt <= 24'd1)
          begin
            state        <= SIG_START;
            refmux       <= REFMUX_NONE;
            sigmux       <= 1'b1;
            ap_cnt       <= cfg.aperture;
            cmpr_disable <= 1'b0;
          end
          else
            phase_cnt <= phase_cnt - 1'b1;
        end

        // one clock of signal alone before the references start
        SIG_START:
        begin
          state     <= FIX_POS_START;
          refmux    <= REFMUX_POS;
          phase_cnt <= cfg.fix_len - 1'b1;
        end

        FIX_POS_START, FIX_POS:
        begin
          if (phase_cnt == '0)
          begin
            state     <= VAR_START;
            refmux    <= var_mux;
            dir_up    <= cmpr_s;
            phase_cnt <= cfg.var_len - 1'b1;
          end
          else
          begin
            state     <= FIX_POS;
            phase_cnt <= phase_cnt - 1'b1;
          end
        end

        VAR_START, VAR:
        begin
          if (phase_cnt == '0)
          begin
            state     <= FIX_NEG_START;
            refmux    <= REFMUX_NEG;
            phase_cnt <= cfg.fix_len - 1'b1;
          end
          else
          begin
            state     <= VAR;
            phase_cnt <= phase_cnt - 1'b1;
          end
        end

        FIX_NEG_START, FIX_NEG:
        begin
          if (phase_cnt == '0)
          begin
            state     <= VAR2_START;
            refmux    <= var_mux;
            dir_up    <= cmpr_s;
            phase_cnt <= cfg.var_len - 1'b1;
          end
          else
          begin
            state     <= FIX_NEG;
            phase_cnt <= phase_cnt - 1'b1;
          end
        end

        VAR2_START, VAR2:
        begin
          if (phase_cnt == '0)
          begin
            // leave only with signal off, last var driven up, and now above the cross
            if (!sigmux && dir_up && !cmpr_s)
            begin
              state  <= PRERUNDOWN;
              refmux <= REFMUX_NEG;
            end
            else
            begin
              state     <= FIX_POS_START;
              refmux    <= REFMUX_POS;
              phase_cnt <= cfg.fix_len - 1'b1;
            end
          end
          else
          begin
            state     <= VAR2;
            phase_cnt <= phase_cnt - 1'b1;
          end
        end

        // one more up clock so rundown always has a crossing ahead
        PRERUNDOWN:
        begin
          state  <= RUNDOWN_START;
          refmux <= rundown_mux;
        end

        RUNDOWN_START, RUNDOWN:
        begin
          if (cmpr_cross)
          begin
            state        <= DONE;
            refmux       <= REFMUX_RESET;
            cmpr_disable <= 1'b1;
            capture_q    <= 1'b1;
          end
          else
            state <= RUNDOWN;
        end

        default: state <= DONE;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // event flags for the counting side

  always_comb
  begin
    ev.refmux      = refmux;
    ev.sigmux      = sigmux;
    ev.clear       = state == RESET_START;
    ev.in_rundown  = (state == RUNDOWN_START) || (state == RUNDOWN);
    ev.cycle_start = state == FIX_POS_START;
    ev.var_up      = ((state == VAR_START) || (state == VAR2_START)) && dir_up;
    ev.var_down    = ((state == VAR_START) || (state == VAR2_START)) && !dir_up;
    // first clock back in done, after the last rundown clock was counted
    ev.capture     = capture_q;
  end

  // signal and integrator short never overlap
  a_no_sig_in_reset: assert property (
    @(posedge clk) disable iff (rst)
    !(sigmux && (refmux == REFMUX_RESET))
  );

  // zero phase lengths from the register block would wrap phase_cnt
  a_phase_len_set: assert property (
    @(posedge clk) disable iff (rst)
    trigger |-> ((cfg.fix_len != '0) && (cfg.var_len != '0))
  );

endmodule

`default_nettype wire

// ==== source/adc_apb_regs.sv ====
`default_nettype none

module adc_apb_regs (
  input  wire                           clk,
  input  wire                           rst,
  input  wire                           psel,
  input  wire                           penable,
  input  wire                           pwrite,
  input  wire [adc_pkg::APB_ADDR_W-1:0] paddr,
  input  wire [31:0]                    pwdata,
  output logic [31:0]                   prdata,
  output logic                          pready,
  output logic                          pslverr,
  output adc_pkg::adc_cfg_t             cfg,
  output logic                          trigger,
  input  wire adc_pkg::adc_result_t     last,
  input  wire                           valid
);
  import adc_pkg::*;

  logic access;
  logic wr_en;
  logic addr_cfg;
  logic addr_result;

  //////////////////////////////////////////////////
  // transfer decode

  // zero wait state slave
  assign pready = 1'b1;

  // access phase completes the transfer
  assign access = psel && penable;
  assign wr_en  = access && pwrite;

  always_comb
  begin
    addr_cfg    = paddr inside {REG_CTRL, REG_APERTURE, REG_RESET, REG_FIX, REG_VAR, REG_MODE};
    addr_result = paddr inside {REG_RESET_CLKS, REG_SIG_CLKS, REG_POS_CLKS, REG_NEG_CLKS,
                                REG_RUNDOWN_CLKS, REG_CYCLES, REG_VAR_UPS, REG_VAR_DOWNS};
  end

  // holes in the map, and results are read only
  assign pslverr = access && (!(addr_cfg || addr_result) || (pwrite && addr_result));

  // start pulse lasts just the access cycle
  // a start during a conversion restarts it
  assign trigger = wr_en && (paddr == REG_CTRL) && pwdata[0];

  //////////////////////////////////////////////////
  // configuration

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      cfg <= '0;
    end
    else if (wr_en)
    begin
      case (paddr)
        REG_APERTURE: cfg.aperture     <= pwdata;
        REG_RESET:    cfg.reset_len    <= pwdata[SHORT_W-1:0];
        REG_FIX:      cfg.fix_len      <= pwdata[SHORT_W-1:0];
        REG_VAR:      cfg.var_len      <= pwdata[SHORT_W-1:0];
        // bit 0 picks the slow reference for rundown
        REG_MODE:     cfg.slow_rundown <= pwdata[0];
        default:      ;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // readback

  // status in ctrl, short counts zero extended
  always_comb
  begin
    case (paddr)
      REG_CTRL:         prdata = {31'd0, valid};
      REG_APERTURE:     prdata = cfg.aperture;
      REG_RESET:        prdata = 32'(cfg.reset_len);
      REG_FIX:          prdata = 32'(cfg.fix_len);
      REG_VAR:          prdata = 32'(cfg.var_len);
      REG_MODE:         prdata = {31'd0, cfg.slow_rundown};
      REG_RESET_CLKS:   prdata = 32'(last.reset_clks);
      REG_SIG_CLKS:     prdata = last.sig_clks;
      REG_POS_CLKS:     prdata = last.pos_clks;
      REG_NEG_CLKS:     prdata = last.neg_clks;
      REG_RUNDOWN_CLKS: prdata = 32'(last.rundown_clks);
      REG_CYCLES:       prdata = 32'(last.cycles);
      REG_VAR_UPS:      prdata = 32'(last.var_ups);
      REG_VAR_DOWNS:    prdata = 32'(last.var_downs);
      default:          prdata = '0;
    endcase
  end

  // access phase never comes without a select from the master
  a_penable_needs_psel: assert property (
    @(posedge clk) disable iff (rst)
    penable |-> psel
  );

endmodule

`default_nettype wire

// ==== source/adc_pkg.sv ====
`default_nettype none

package adc_pkg;

  //////////////////////////////////////////////////
  // widths

  // apb byte address, word aligned registers
  localparam int APB_ADDR_W = 8;

  // aperture and modulation clock totals need the long form
  localparam int LONG_W  = 32;
  localparam int SHORT_W = 24;

  typedef logic [LONG_W-1:0]  long_cnt_t;
  typedef logic [SHORT_W-1:0] short_cnt_t;

  //////////////////////////////////////////////////
  // switch and state encodings

  // two analog switch banks folded into one code
  // none turns both references off
  typedef enum logic [2:0] {
    REFMUX_NONE     = 3'b000,
    REFMUX_POS      = 3'b001,
    REFMUX_NEG      = 3'b010,
    REFMUX_SLOW_POS = 3'b011,
    REFMUX_RESET    = 3'b100
  } refmux_e;

  // modulation sequence, each timed phase has a start cycle
  typedef enum logic [3:0] {
    DONE,
    RESET_START,
    RESET,
    SIG_START,
    FIX_POS_START,
    FIX_POS,
    VAR_START,
    VAR,
    FIX_NEG_START,
    FIX_NEG,
    VAR2_START,
    VAR2,
    PRERUNDOWN,
    RUNDOWN_START,
    RUNDOWN
  } seq_state_e;

  //////////////////////////////////////////////////
  // bundles between blocks

  // host programmed measurement setup
  typedef struct packed {
    long_cnt_t  aperture;
    short_cnt_t reset_len;
    short_cnt_t fix_len;
    short_cnt_t var_len;
    logic       slow_rundown;
  } adc_cfg_t;

  // per clock view of the sequencer for the counting side
  typedef struct packed {
    refmux_e refmux;
    logic    sigmux;
    logic    clear;
    logic    in_rundown;
    logic    cycle_start;
    logic    var_up;
    logic    var_down;
    logic    capture;
  } seq_event_t;

  // clock and phase totals of one conversion
  typedef struct packed {
    short_cnt_t reset_clks;
    long_cnt_t  sig_clks;
    long_cnt_t  pos_clks;
    long_cnt_t  neg_clks;
    short_cnt_t rundown_clks;
    short_cnt_t cycles;
    short_cnt_t var_ups;
    short_cnt_t var_downs;
  } adc_result_t;

  //////////////////////////////////////////////////
  // register map

  localparam logic [APB_ADDR_W-1:0] REG_CTRL     = 8'h00;
  localparam logic [APB_ADDR_W-1:0] REG_APERTURE = 8'h04;
  localparam logic [APB_ADDR_W-1:0] REG_RESET    = 8'h08;
  localparam logic [APB_ADDR_W-1:0] REG_FIX      = 8'h0C;
  localparam logic [APB_ADDR_W-1:0] REG_VAR      = 8'h10;
  localparam logic [APB_ADDR_W-1:0] REG_MODE     = 8'h14;

  // read only results, same order as adc_result_t
  localparam logic [APB_ADDR_W-1:0] REG_RESET_CLKS   = 8'h20;
  localparam logic [APB_ADDR_W-1:0] REG_SIG_CLKS     = 8'h24;
  localparam logic [APB_ADDR_W-1:0] REG_POS_CLKS     = 8'h28;
  localparam logic [APB_ADDR_W-1:0] REG_NEG_CLKS     = 8'h2C;
  localparam logic [APB_ADDR_W-1:0] REG_RUNDOWN_CLKS = 8'h30;
  localparam logic [APB_ADDR_W-1:0] REG_CYCLES       = 8'h34;
  localparam logic [APB_ADDR_W-1:0] REG_VAR_UPS      = 8'h38;
  localparam logic [APB_ADDR_W-1:0] REG_VAR_DOWNS    = 8'h3C;

endpackage

`default_nettype wire
